//--- list.f
logic/stepper_pkg.sv
logic/chopper_if.sv
logic/phase_sequencer.sv
logic/coil_chopper.sv
logic/bridge_driver.sv
logic/microstepper_top.sv
sim/microstepper_tb.sv

//--- sim/microstepper_tb.sv
`timescale 1ns/1ps

module microstepper_tb import stepper_pkg::*;;

  localparam int act_wait    = 0;
  localparam int act_step    = 1;
  localparam int act_enable  = 2;
  localparam int act_cmp_a   = 3;
  localparam int act_fault_b = 4;
  localparam int act_invert  = 5;

  logic       clk, rst_n, step, dir, enable, analog_cmp1, analog_cmp2;
  logic       invert_highside, invert_lowside, fault;
  off_t       fastdecay_threshold, off_time;
  blank_t     blank_time;
  min_on_t    min_on_time;
  logic [3:0] s_h, s_l;
  logic [7:0] phase_ct;

  // each row is an action, its cycle budget and the expected coil and fault state.
  int     act_tbl [0:31];
  int     cnt_tbl [0:31];
  logic   dir_tbl [0:31];
  int     settle_tbl [0:31];
  decay_e dec_a_tbl [0:31];
  decay_e dec_b_tbl [0:31];
  logic   flt_tbl [0:31];
  int     n_rows = 0;

  int     exp_phase = 0;
  logic   en_model = 1'b0;
  int     cycle_count = 0;
  int     limit = 0;
  integer seed = 32'h38a5;

  microstepper_top microstepper_top_inst (
    .clk (clk), .rst_n (rst_n), .step (step), .dir (dir), .enable (enable),
    .analog_cmp1 (analog_cmp1), .analog_cmp2 (analog_cmp2),
    .fastdecay_threshold (fastdecay_threshold), .off_time (off_time),
    .blank_time (blank_time), .min_on_time (min_on_time),
    .invert_highside (invert_highside), .invert_lowside (invert_lowside),
    .s_h (s_h), .s_l (s_l), .fault (fault), .phase_ct (phase_ct)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (limit > 0 && cycle_count >= limit) begin
      $display("timeout: no result after %0d clock cycles", cycle_count);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // the leg table, written s1..s4 from the left and returned with s1 in bit 0.
  function automatic logic [3:0] leg_pattern(input int ph);
    logic [3:0] s;
    case (ph % 4)
      0:       s = 4'b1010;
      1:       s = 4'b0110;
      2:       s = 4'b0101;
      default: s = 4'b1001;
    endcase
    return {s[0], s[1], s[2], s[3]};
  endfunction

  // returns {s_h, s_l} for the given phase and coil decay modes.
  function automatic logic [7:0] expected_gates(input int ph, input decay_e da,
                                                input decay_e db, input logic ih,
                                                input logic il, input logic en,
                                                input logic flt);
    logic [3:0] lg, hi, lo;
    decay_e     dm;
    lg = leg_pattern(ph);
    for (int i = 0; i < 4; i++) begin
      dm = (i < 2) ? da : db;
      if (dm == decay_fast) begin
        hi[i] = ~lg[i];
        lo[i] = lg[i];
      end else if (dm == decay_slow) begin
        hi[i] = 1'b0;
        lo[i] = 1'b1;
      end else begin
        hi[i] = lg[i];
        lo[i] = ~lg[i];
      end
    end
    hi = hi ^ {4{ih}};
    lo = lo ^ {4{il}};
    if (!en || flt) begin
      hi = 4'b0000;
      lo = 4'b0000;
    end
    return {hi, lo};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic add_row(input int act, input int cnt, input logic d, input int settle,
                         input decay_e da, input decay_e db, input logic flt);
    act_tbl[n_rows]    = act;
    cnt_tbl[n_rows]    = cnt;
    dir_tbl[n_rows]    = d;
    settle_tbl[n_rows] = settle;
    dec_a_tbl[n_rows]  = da;
    dec_b_tbl[n_rows]  = db;
    flt_tbl[n_rows]    = flt;
    n_rows = n_rows + 1;
  endtask

  // each step is high for 2 cycles and low for 2 cycles.
  task automatic apply_steps(input int k, input logic d, inout int used);
    dir = d;
    for (int i = 0; i < k; i++) begin
      step = 1'b1;
      wait_cycles(2);
      step = 1'b0;
      wait_cycles(2);
      used = used + 4;
      if (en_model) begin
        exp_phase = d ? (exp_phase + 1) % 256 : (exp_phase + 255) % 256;
      end
    end
  endtask

  task automatic run_row(input int r);
    int         used;
    logic [7:0] gates;
    used = 0;
    case (act_tbl[r])
      act_step: apply_steps(cnt_tbl[r], dir_tbl[r], used);
      act_enable: begin
        enable   = cnt_tbl[r][0];
        en_model = cnt_tbl[r][0];
      end
      act_cmp_a: begin
        analog_cmp1 = 1'b1;
        wait_cycles(2);
        analog_cmp1 = 1'b0;
        used = 2;
      end
      act_fault_b: begin
        // from an odd phase an up step moves coil b, from an even one a down step.
        apply_steps(1, exp_phase[0], used);
        analog_cmp2 = 1'b1;
        wait_cycles(6);
        analog_cmp2 = 1'b0;
        used = used + 6;
      end
      act_invert: begin
        invert_highside = cnt_tbl[r][0];
        invert_lowside  = cnt_tbl[r][1];
      end
      default: ;
    endcase
    wait_cycles(settle_tbl[r] - used);
    @(negedge clk);
    gates = expected_gates(exp_phase, dec_a_tbl[r], dec_b_tbl[r], invert_highside,
                           invert_lowside, en_model, flt_tbl[r]);
    check_value(phase_ct, exp_phase, $sformatf("row %0d phase_ct", r));
    check_value(fault, flt_tbl[r], $sformatf("row %0d fault", r));
    check_value(s_h, gates[7:4], $sformatf("row %0d s_h", r));
    check_value(s_l, gates[3:0], $sformatf("row %0d s_l", r));
  endtask

  initial begin
    int r1, r2, k, total;
    clk = 1'b0;
    rst_n = 1'b0;
    step = 1'b0;
    dir = 1'b0;
    enable = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    invert_highside = 1'b0;
    invert_lowside = 1'b0;
    blank_time = 8'd4;
    min_on_time = 8'd6;
    off_time = 10'd20;
    fastdecay_threshold = 10'd12;

    r1 = $random(seed) & 3;
    r2 = $random(seed) & 3;
    add_row(act_enable, 1, 1'b0, 6, decay_drive, decay_drive, 1'b0);
    add_row(act_step, 3, 1'b1, 13, decay_drive, decay_drive, 1'b0);
    // down past zero, then back up past 255.
    k = 5 + r1;
    add_row(act_step, k, 1'b0, 4 * k + 1, decay_drive, decay_drive, 1'b0);
    k = 3 + r1 + r2;
    add_row(act_step, k, 1'b1, 4 * k + 1, decay_drive, decay_drive, 1'b0);
    add_row(act_wait, 0, 1'b0, 20, decay_drive, decay_drive, 1'b0);
    // checks land 4, 10, 14, 22 and 30 cycles after the comparator rise.
    add_row(act_cmp_a, 0, 1'b0, 4, decay_fast, decay_drive, 1'b0);
    add_row(act_wait, 0, 1'b0, 5, decay_fast, decay_drive, 1'b0);
    add_row(act_wait, 0, 1'b0, 3, decay_slow, decay_drive, 1'b0);
    add_row(act_wait, 0, 1'b0, 7, decay_slow, decay_drive, 1'b0);
    add_row(act_wait, 0, 1'b0, 7, decay_drive, decay_drive, 1'b0);
    add_row(act_fault_b, 0, 1'b0, 14, decay_drive, decay_drive, 1'b1);
    add_row(act_step, 2, 1'b1, 9, decay_drive, decay_drive, 1'b1);
    add_row(act_enable, 0, 1'b0, 30, decay_drive, decay_drive, 1'b0);
    add_row(act_step, 2, 1'b1, 9, decay_drive, decay_drive, 1'b0);
    add_row(act_enable, 1, 1'b0, 6, decay_drive, decay_drive, 1'b0);
    add_row(act_invert, 1, 1'b0, 3, decay_drive, decay_drive, 1'b0);
    add_row(act_invert, 2, 1'b0, 3, decay_drive, decay_drive, 1'b0);
    add_row(act_invert, 0, 1'b0, 3, decay_drive, decay_drive, 1'b0);
    add_row(act_step, 1, 1'b0, 5, decay_drive, decay_drive, 1'b0);

    total = 0;
    for (int i = 0; i < n_rows; i++) begin
      total = total + settle_tbl[i];
    end
    limit = 2 * total + 100;

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      #1;
      run_row(r);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- logic/microstepper_top.sv
`timescale 1ns/1ps

module microstepper_top import stepper_pkg::*; #(
  parameter int phase_w = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               step,
  input  logic               dir,
  input  logic               enable,
  input  logic               analog_cmp1,
  input  logic               analog_cmp2,
  input  off_t               fastdecay_threshold,
  input  off_t               off_time,
  input  blank_t             blank_time,
  input  min_on_t            min_on_time,
  input  logic               invert_highside,
  input  logic               invert_lowside,
  output logic [3:0]         s_h,
  output logic [3:0]         s_l,
  output logic               fault,
  output logic [phase_w-1:0] phase_ct
);

  logic [3:0] legs;
  logic       enabled, fault_clear;
  logic       coil_start_a, coil_start_b;
  logic       fault_a, fault_b;

  chopper_if chop_a ();
  chopper_if chop_b ();

  phase_sequencer #(
    .phase_w (phase_w)
  ) phase_sequencer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .phase_ct    (phase_ct),
    .legs        (legs),
    .enabled     (enabled),
    .fault_clear (fault_clear)
  );

  // coil a is s1/s2 and senses on cmp1, coil b is s3/s4 on cmp2.
  coil_chopper coil_chopper_a (
    .clk         (clk),
    .rst_n       (rst_n),
    .analog_cmp  (analog_cmp1),
    .starting    (coil_start_a),
    .off_time    (off_time),
    .blank_time  (blank_time),
    .min_on_time (min_on_time),
    .fault_clear (fault_clear),
    .chop        (chop_a.driver),
    .fault_coil  (fault_a)
  );

  coil_chopper coil_chopper_b (
    .clk         (clk),
    .rst_n       (rst_n),
    .analog_cmp  (analog_cmp2),
    .starting    (coil_start_b),
    .off_time    (off_time),
    .blank_time  (blank_time),
    .min_on_time (min_on_time),
    .fault_clear (fault_clear),
    .chop        (chop_b.driver),
    .fault_coil  (fault_b)
  );

  bridge_driver bridge_driver_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .legs                (legs),
    .enabled             (enabled),
    .fastdecay_threshold (fastdecay_threshold),
    .invert_highside     (invert_highside),
    .invert_lowside      (invert_lowside),
    .fault_a             (fault_a),
    .fault_b             (fault_b),
    .chop_a              (chop_a.monitor),
    .chop_b              (chop_b.monitor),
    .coil_start_a        (coil_start_a),
    .coil_start_b        (coil_start_b),
    .s_h                 (s_h),
    .s_l                 (s_l),
    .fault               (fault)
  );

endmodule

//--- logic/bridge_driver.sv
`timescale 1ns/1ps

module bridge_driver import stepper_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [3:0] legs,
  input  logic       enabled,
  input  off_t       fastdecay_threshold,
  input  logic       invert_highside,
  input  logic       invert_lowside,
  input  logic       fault_a,
  input  logic       fault_b,
  chopper_if.monitor chop_a,
  chopper_if.monitor chop_b,
  output logic       coil_start_a,
  output logic       coil_start_b,
  output logic [3:0] s_h,
  output logic [3:0] s_l,
  output logic       fault
);

  logic [3:0] leg_d1, leg_d2;
  logic [3:0] leg_rise;
  decay_e     decay_a, decay_b;
  logic       gate_en;

  function automatic decay_e decay_of(chop_state_e st, off_t ot, off_t thr);
    if (st != chop_off || ot == '0) begin
      return decay_drive;
    end
    if (ot >= thr) begin
      return decay_fast;
    end
    return decay_slow;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      leg_d1 <= '0;
      leg_d2 <= '0;
    end else begin
      leg_d1 <= legs;
      leg_d2 <= leg_d1;
    end
  end

  assign leg_rise     = leg_d1 & ~leg_d2;
  assign coil_start_a = |leg_rise[1:0];
  assign coil_start_b = |leg_rise[3:2];

  assign decay_a = decay_of(chop_a.state, chop_a.off_timer, fastdecay_threshold);
  assign decay_b = decay_of(chop_b.state, chop_b.off_timer, fastdecay_threshold);

  assign fault   = fault_a | fault_b;
  assign gate_en = enabled & ~fault;

  always_comb begin
    decay_e dm;
    logic   hi, lo;
    for (int i = 0; i < 4; i++) begin
      dm = (i < 2) ? decay_a : decay_b;
      case (dm)
        decay_fast: begin
          hi = ~legs[i];
          lo = legs[i];
        end
        decay_slow: begin
          hi = 1'b0;
          lo = 1'b1;
        end
        default: begin
          hi = legs[i];
          lo = ~legs[i];
        end
      endcase
      s_h[i] = (hi ^ invert_highside) & gate_en;
      s_l[i] = (lo ^ invert_lowside) & gate_en;
    end
  end

  // a restart lands in blanking, blanking is always driven, and a coil
  // fault only rises out of the minimum on window.
  property p_coil(logic start, chop_state_e st, blank_t bt, min_on_t mt,
                  decay_e dm, logic flt);
    @(posedge clk) disable iff (!rst_n)
      (start |=> st == chop_blank) and
      (bt != '0 |-> dm == decay_drive) and
      ($rose(flt) |-> $past(mt) != '0);
  endproperty

  assert property (p_coil(chop_a.starting, chop_a.state, chop_a.blank_timer,
                          chop_a.min_on_timer, decay_a, fault_a));
  assert property (p_coil(chop_b.starting, chop_b.state, chop_b.blank_timer,
                          chop_b.min_on_timer, decay_b, fault_b));

  // no shoot-through on any leg.
  assert property (@(posedge clk) disable iff (!rst_n)
    (!invert_highside && !invert_lowside) |-> (s_h & s_l) == 4'b0000);

endmodule

//--- logic/coil_chopper.sv
`timescale 1ns/1ps

module coil_chopper import stepper_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      analog_cmp,
  input  logic      starting,
  input  off_t      off_time,
  input  blank_t    blank_time,
  input  min_on_t   min_on_time,
  input  logic      fault_clear,
  chopper_if.driver chop,
  output logic      fault_coil
);

  chop_state_e state;
  blank_t      blank_timer;
  off_t        off_timer;
  min_on_t     min_on_timer;
  logic        cmp_s1, cmp_s2;
  logic        trip;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmp_s1 <= 1'b0;
      cmp_s2 <= 1'b0;
    end else begin
      cmp_s1 <= analog_cmp;
      cmp_s2 <= cmp_s1;
    end
  end

  // the comparator only counts while the coil is driven and unblanked.
  assign trip = (state == chop_on) && cmp_s2 && !starting;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= chop_blank;
      blank_timer  <= '0;
      off_timer    <= '0;
      min_on_timer <= '0;
    end else begin
      if (min_on_timer != '0) begin
        min_on_timer <= min_on_timer - 1'b1;
      end
      if (starting) begin
        // a new commutation restarts the coil from blanking.
        state        <= chop_blank;
        blank_timer  <= blank_time;
        min_on_timer <= min_on_time;
        off_timer    <= '0;
      end else begin
        case (state)
          chop_blank: begin
            if (blank_timer <= blank_t'(1)) begin
              blank_timer <= '0;
              state       <= chop_on;
            end else begin
              blank_timer <= blank_timer - 1'b1;
            end
          end
          chop_on: begin
            if (trip) begin
              off_timer <= off_time;
              state     <= chop_off;
            end
          end
          default: begin
            if (off_timer <= off_t'(1)) begin
              off_timer   <= '0;
              blank_timer <= blank_time;
              state       <= chop_blank;
            end else begin
              off_timer <= off_timer - 1'b1;
            end
          end
        endcase
      end
    end
  end

  // sticky until the enable drops.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_coil <= 1'b0;
    end else if (fault_clear) begin
      fault_coil <= 1'b0;
    end else if (trip && min_on_timer != '0) begin
      fault_coil <= 1'b1;
    end
  end

  assign chop.state        = state;
  assign chop.off_timer    = off_timer;
  assign chop.min_on_timer = min_on_timer;
  assign chop.blank_timer  = blank_timer;
  assign chop.starting     = starting;

  assert property (@(posedge clk) disable iff (!rst_n)
    !((blank_timer != '0) && (off_timer != '0)));

endmodule

//--- logic/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer #(
  parameter int phase_w = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               step,
  input  logic               dir,
  input  logic               enable,
  output logic [phase_w-1:0] phase_ct,
  output logic [3:0]         legs,
  output logic               enabled,
  output logic               fault_clear
);

  logic step_s1, step_s2, step_d;
  logic dir_s1, dir_s2;
  logic en_s1, en_s2;
  logic step_rise;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_s1 <= 1'b0;
      step_s2 <= 1'b0;
      step_d  <= 1'b0;
      dir_s1  <= 1'b0;
      dir_s2  <= 1'b0;
      en_s1   <= 1'b0;
      en_s2   <= 1'b0;
    end else begin
      step_s1 <= step;
      step_s2 <= step_s1;
      step_d  <= step_s2;
      dir_s1  <= dir;
      dir_s2  <= dir_s1;
      en_s1   <= enable;
      en_s2   <= en_s1;
    end
  end

  assign step_rise   = step_s2 & ~step_d;
  assign enabled     = en_s2;
  assign fault_clear = ~en_s2;

  // the counter wraps at its own width in both directions.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_ct <= '0;
    end else if (en_s2 && step_rise) begin
      phase_ct <= dir_s2 ? phase_ct + 1'b1 : phase_ct - 1'b1;
    end
  end

  // legs[0] is s1 and legs[3] is s4, so each constant reads s4..s1.
  always_comb begin
    case (phase_ct[1:0])
      2'd0:    legs = 4'b0101;
      2'd1:    legs = 4'b0110;
      2'd2:    legs = 4'b1010;
      default: legs = 4'b1001;
    endcase
  end

  // one leg per coil is active, and a full step moves only one coil.
  assert property (@(posedge clk) disable iff (!rst_n)
    (legs[0] != legs[1]) && (legs[2] != legs[3]) &&
    ((legs[1:0] == $past(legs[1:0])) || (legs[3:2] == $past(legs[3:2]))));

endmodule

//--- logic/chopper_if.sv
`timescale 1ns/1ps

interface chopper_if import stepper_pkg::*; ();

  chop_state_e state;
  off_t        off_timer;
  min_on_t     min_on_timer;
  blank_t      blank_timer;
  logic        starting;

  modport driver (
    output state,
    output off_timer,
    output min_on_timer,
    output blank_timer,
    output starting
  );

  modport monitor (
    input state,
    input off_timer,
    input min_on_timer,
    input blank_timer,
    input starting
  );

endinterface

//--- logic/stepper_pkg.sv
package stepper_pkg;

  // blanking count after a commutation or an off period, in clock cycles.
  typedef logic [7:0] blank_t;

  // off-time count; the fast-decay threshold shares this width.
  typedef logic [9:0] off_t;

  // minimum on-time count; a trip inside this window is a fault.
  typedef logic [7:0] min_on_t;

  // how the bridge treats a coil in the current cycle.
  typedef enum logic [1:0] {
    decay_drive,
    decay_fast,
    decay_slow
  } decay_e;

  // chopper state for one coil.
  typedef enum logic [1:0] {
    chop_blank,
    chop_on,
    chop_off
  } chop_state_e;

endpackage
